// ==== src/cache_bus_pkg.sv ====
/*
  Shared widths and packet types for the cache-side bus adapter.
  Bus words are 32 bits and a cache line is four bus words.
  Atomics, invalidations and user sideband bits are not carried.
*/
`default_nettype none

package cache_bus_pkg;

  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned BUS_W      = 32;
  localparam int unsigned LINE_W     = 128;
  localparam int unsigned LINE_BEATS = LINE_W / BUS_W;
  localparam int unsigned BLEN_W     = 2;
  localparam int unsigned BE_W       = BUS_W / 8;
  localparam int unsigned TID_W      = 2;
  localparam int unsigned MAX_SIZE   = 2;

  typedef logic [LINE_BEATS-1:0][BUS_W-1:0] line_t;

  //////////////////////////////////////////////////
  // cache requests
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              nc;
    logic [TID_W-1:0]  tid;
  } icache_req_t;

  typedef enum logic {
    DCACHE_LOAD_REQ  = 1'b0,
    DCACHE_STORE_REQ = 1'b1
  } dcache_req_type_e;

  // size bit 2 asks for a whole line
  typedef struct packed {
    dcache_req_type_e  rtype;
    logic [ADDR_W-1:0] paddr;
    logic [2:0]        size;
    logic [BUS_W-1:0]  data;
    logic [TID_W-1:0]  tid;
  } dcache_req_t;

  //////////////////////////////////////////////////
  // return packets
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [TID_W-1:0] tid;
    line_t            line;
  } icache_rtrn_t;

  typedef enum logic {
    DCACHE_LOAD_ACK  = 1'b0,
    DCACHE_STORE_ACK = 1'b1
  } dcache_rtrn_type_e;

  typedef struct packed {
    dcache_rtrn_type_e rtype;
    logic [TID_W-1:0]  tid;
    line_t             line;
  } dcache_rtrn_t;

  //////////////////////////////////////////////////
  // bus commands
  //////////////////////////////////////////////////

  // id is 1 for the data cache
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [BLEN_W-1:0] blen;
    logic [2:0]        size;
    logic              id;
  } bus_rd_cmd_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [BUS_W-1:0]  data;
    logic [BE_W-1:0]   be;
    logic [2:0]        size;
  } bus_wr_cmd_t;

  // report of a command accepted by the bus
  typedef struct packed {
    logic             icache_rd;
    logic             dcache_rd;
    logic             dcache_wr;
    logic [TID_W-1:0] icache_tid;
    logic [TID_W-1:0] dcache_tid;
  } tid_push_t;

endpackage

`default_nettype wire

// ==== src/sync_fifo.sv ====
/*
  Synchronous FIFO, head always visible on data_o (no fall-through).
  Pushing when full or popping when empty is illegal.
*/
`default_nettype none

module sync_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 4
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             push_i,
  input  wire logic [WIDTH-1:0] data_i,
  input  wire logic             pop_i,
  output logic      [WIDTH-1:0] data_o,
  output logic                  full_o,
  output logic                  empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // the producer and consumer live in other modules and must honour the flags
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("sync_fifo: push while full");
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
    else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== src/req_arbiter.sv ====
/*
  Round-robin between the instruction and data cache queues.
  The choice is locked until the bus grants the command.
  Stores must be naturally aligned, byte enables do not wrap.
*/
`default_nettype none

module req_arbiter
  import cache_bus_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire icache_req_t icache_req_i,
  input  wire logic        icache_vld_i,
  input  wire dcache_req_t dcache_req_i,
  input  wire logic        dcache_vld_i,
  input  wire logic        icache_rd_full_i,
  input  wire logic        dcache_rd_full_i,
  input  wire logic        dcache_wr_full_i,
  input  wire logic        bus_rd_gnt_i,
  input  wire logic        bus_wr_gnt_i,
  output logic             icache_pop_o,
  output logic             dcache_pop_o,
  output logic             bus_rd_req_o,
  output bus_rd_cmd_t      bus_rd_cmd_o,
  output logic             bus_wr_req_o,
  output bus_wr_cmd_t      bus_wr_cmd_o,
  output tid_push_t        tid_push_o
);

  logic icache_elig, dcache_elig, dcache_store;
  logic sel, req_vld, rd_acc, wr_acc, gnt;
  logic lock_q, sel_q, prio_q;

  assign dcache_store = (dcache_req_i.rtype == DCACHE_STORE_REQ);
  assign icache_elig  = icache_vld_i & ~icache_rd_full_i;
  assign dcache_elig  = dcache_vld_i & (dcache_store ? ~dcache_wr_full_i : ~dcache_rd_full_i);

  // sel = 1 picks the data cache
  always_comb begin
    if (lock_q) begin
      sel = sel_q;
    end else if (icache_elig && dcache_elig) begin
      sel = prio_q;
    end else begin
      sel = dcache_elig;
    end
  end

  assign req_vld      = sel ? dcache_elig : icache_elig;
  assign bus_rd_req_o = req_vld & ~(sel & dcache_store);
  assign bus_wr_req_o = req_vld & sel & dcache_store;

  assign rd_acc = bus_rd_req_o & bus_rd_gnt_i;
  assign wr_acc = bus_wr_req_o & bus_wr_gnt_i;
  assign gnt    = rd_acc | wr_acc;

  assign icache_pop_o = gnt & ~sel;
  assign dcache_pop_o = gnt & sel;

  assign tid_push_o.icache_rd  = rd_acc & ~sel;
  assign tid_push_o.dcache_rd  = rd_acc & sel;
  assign tid_push_o.dcache_wr  = wr_acc;
  assign tid_push_o.icache_tid = icache_req_i.tid;
  assign tid_push_o.dcache_tid = dcache_req_i.tid;

  //////////////////////////////////////////////////
  // command encoding
  //////////////////////////////////////////////////

  always_comb begin
    bus_rd_cmd_o.id = sel;
    if (sel) begin
      bus_rd_cmd_o.addr = dcache_req_i.paddr;
      // line loads read full words in a burst
      bus_rd_cmd_o.size = dcache_req_i.size[2] ? 3'(MAX_SIZE) : dcache_req_i.size;
      bus_rd_cmd_o.blen = dcache_req_i.size[2] ? BLEN_W'(LINE_BEATS - 1) : '0;
    end else begin
      bus_rd_cmd_o.addr = icache_req_i.paddr;
      bus_rd_cmd_o.size = 3'(MAX_SIZE);
      bus_rd_cmd_o.blen = icache_req_i.nc ? '0 : BLEN_W'(LINE_BEATS - 1);
    end
  end

  always_comb begin
    bus_wr_cmd_o.addr = dcache_req_i.paddr;
    bus_wr_cmd_o.data = dcache_req_i.data;
    bus_wr_cmd_o.size = dcache_req_i.size;
    unique case (dcache_req_i.size[1:0])
      2'b00:   bus_wr_cmd_o.be = BE_W'(4'b0001) << dcache_req_i.paddr[1:0];
      2'b01:   bus_wr_cmd_o.be = BE_W'(4'b0011) << dcache_req_i.paddr[1:0];
      default: bus_wr_cmd_o.be = BE_W'(4'b1111) << dcache_req_i.paddr[1:0];
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
      sel_q  <= 1'b0;
      prio_q <= 1'b0;
    end else begin
      lock_q <= req_vld & ~gnt;
      sel_q  <= sel;
      // the other side goes first next time
      if (gnt) begin
        prio_q <= ~sel;
      end
    end
  end

  a_rd_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rd_req_o && !bus_rd_gnt_i |=> bus_rd_req_o && $stable(bus_rd_cmd_o))
    else $error("req_arbiter: read command changed before grant");
  a_wr_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_wr_req_o && !bus_wr_gnt_i |=> bus_wr_req_o && $stable(bus_wr_cmd_o))
    else $error("req_arbiter: write command changed before grant");

endmodule

`default_nettype wire

// ==== src/tid_tracker.sv ====
/*
  Outstanding transaction IDs in issue order, one queue per stream.
  Relies on the bus returning reads in order per ID and writes in order.
*/
`default_nettype none

module tid_tracker
  import cache_bus_pkg::*;
#(
  parameter int unsigned META_DEPTH = 4
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire tid_push_t        tid_push_i,
  input  wire logic             icache_rd_pop_i,
  input  wire logic             dcache_rd_pop_i,
  input  wire logic             dcache_wr_pop_i,
  output logic      [TID_W-1:0] icache_tid_o,
  output logic      [TID_W-1:0] dcache_rd_tid_o,
  output logic      [TID_W-1:0] dcache_wr_tid_o,
  output logic                  icache_rd_full_o,
  output logic                  dcache_rd_full_o,
  output logic                  dcache_wr_full_o,
  output logic                  dcache_wr_empty_o
);

  sync_fifo #(.WIDTH(TID_W), .DEPTH(META_DEPTH)) u_icache_rd_tid (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (tid_push_i.icache_rd),
    .data_i (tid_push_i.icache_tid),
    .pop_i  (icache_rd_pop_i),
    .data_o (icache_tid_o),
    .full_o (icache_rd_full_o),
    .empty_o()
  );

  sync_fifo #(.WIDTH(TID_W), .DEPTH(META_DEPTH)) u_dcache_rd_tid (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (tid_push_i.dcache_rd),
    .data_i (tid_push_i.dcache_tid),
    .pop_i  (dcache_rd_pop_i),
    .data_o (dcache_rd_tid_o),
    .full_o (dcache_rd_full_o),
    .empty_o()
  );

  // stores all belong to the data cache
  sync_fifo #(.WIDTH(TID_W), .DEPTH(META_DEPTH)) u_dcache_wr_tid (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (tid_push_i.dcache_wr),
    .data_i (tid_push_i.dcache_tid),
    .pop_i  (dcache_wr_pop_i),
    .data_o (dcache_wr_tid_o),
    .full_o (dcache_wr_full_o),
    .empty_o(dcache_wr_empty_o)
  );

endmodule

`default_nettype wire

// ==== src/rtrn_assembler.sv ====
/*
  Builds return packets from bus read beats and write responses.
  Caches must take returns in the cycle they are valid.
  Words above word 0 are undefined after a single-beat read.
*/
`default_nettype none

module rtrn_assembler
  import cache_bus_pkg::*;
#(
  parameter int unsigned META_DEPTH = 4
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             bus_rd_valid_i,
  input  wire logic [BUS_W-1:0] bus_rd_data_i,
  input  wire logic             bus_rd_last_i,
  input  wire logic             bus_rd_id_i,
  input  wire logic             bus_wr_valid_i,
  input  wire logic [TID_W-1:0] icache_tid_i,
  input  wire logic [TID_W-1:0] dcache_rd_tid_i,
  input  wire logic [TID_W-1:0] dcache_wr_tid_i,
  input  wire logic             dcache_wr_empty_i,
  output logic                  bus_wr_rdy_o,
  output logic                  icache_rd_pop_o,
  output logic                  dcache_rd_pop_o,
  output logic                  dcache_wr_pop_o,
  output logic                  icache_rtrn_vld_o,
  output icache_rtrn_t          icache_rtrn_o,
  output logic                  dcache_rtrn_vld_o,
  output dcache_rtrn_t          dcache_rtrn_o
);

  logic [1:0] beat_en;
  logic b_full, b_empty, b_pop;
  logic icache_vld_q, dcache_vld_q;
  logic [TID_W-1:0] icache_tid_q, dcache_tid_q;
  dcache_rtrn_type_e dcache_type_q;

  // index 0 is the instruction cache, 1 the data cache
  assign beat_en = {bus_rd_valid_i & bus_rd_id_i, bus_rd_valid_i & ~bus_rd_id_i};

  //////////////////////////////////////////////////
  // write response buffer
  //////////////////////////////////////////////////

  assign bus_wr_rdy_o = ~b_full;

  sync_fifo #(.WIDTH(1), .DEPTH(META_DEPTH)) u_wr_rsp (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (bus_wr_valid_i & bus_wr_rdy_o),
    .data_i (1'b1),
    .pop_i  (b_pop),
    .data_o (),
    .full_o (b_full),
    .empty_o(b_empty)
  );

  // read beats win, a buffered response waits a cycle
  assign b_pop           = ~b_empty & ~beat_en[1];
  assign icache_rd_pop_o = beat_en[0] & bus_rd_last_i;
  assign dcache_rd_pop_o = beat_en[1] & bus_rd_last_i;
  assign dcache_wr_pop_o = b_pop;

  //////////////////////////////////////////////////
  // line assembly
  //////////////////////////////////////////////////

  for (genvar c = 0; c < 2; c++) begin : g_asm
    line_t shift_q;
    logic  first_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        first_q <= 1'b1;
      end else if (beat_en[c]) begin
        first_q <= bus_rd_last_i;
      end
    end

    // beats shift in at the top, a lone beat also lands in word 0
    always_ff @(posedge clk_i) begin
      if (beat_en[c]) begin
        shift_q <= {bus_rd_data_i, shift_q[LINE_BEATS-1:1]};
        if (first_q) begin
          shift_q[0] <= bus_rd_data_i;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // registered return
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      icache_vld_q <= 1'b0;
      dcache_vld_q <= 1'b0;
    end else begin
      icache_vld_q <= icache_rd_pop_o;
      dcache_vld_q <= dcache_rd_pop_o | b_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    icache_tid_q  <= icache_tid_i;
    dcache_tid_q  <= b_pop ? dcache_wr_tid_i : dcache_rd_tid_i;
    dcache_type_q <= b_pop ? DCACHE_STORE_ACK : DCACHE_LOAD_ACK;
  end

  assign icache_rtrn_vld_o   = icache_vld_q;
  assign icache_rtrn_o.tid   = icache_tid_q;
  assign icache_rtrn_o.line  = g_asm[0].shift_q;
  assign dcache_rtrn_vld_o   = dcache_vld_q;
  assign dcache_rtrn_o.rtype = dcache_type_q;
  assign dcache_rtrn_o.tid   = dcache_tid_q;
  assign dcache_rtrn_o.line  = g_asm[1].shift_q;

  // every write response must match a store issued by the arbiter
  a_wr_has_tid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_pop |-> !dcache_wr_empty_i)
    else $error("rtrn_assembler: write response without pending store");

endmodule

`default_nettype wire

// ==== src/cache_bus_adapter.sv ====
/*
  Lets an instruction cache and a data cache share one burst bus.
  Returns have no back-pressure, caches must consume them at once.
  Read beats are taken every cycle; write responses honour bus_wr_rdy_o.
*/
`default_nettype none

module cache_bus_adapter
  import cache_bus_pkg::*;
#(
  parameter int unsigned REQ_DEPTH  = 2,
  parameter int unsigned META_DEPTH = 4
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  // instruction cache
  input  wire logic             icache_data_req_i,
  output logic                  icache_data_ack_o,
  input  wire icache_req_t      icache_data_i,
  output logic                  icache_rtrn_vld_o,
  output icache_rtrn_t          icache_rtrn_o,
  // data cache
  input  wire logic             dcache_data_req_i,
  output logic                  dcache_data_ack_o,
  input  wire dcache_req_t      dcache_data_i,
  output logic                  dcache_rtrn_vld_o,
  output dcache_rtrn_t          dcache_rtrn_o,
  // bus
  output logic                  bus_rd_req_o,
  output bus_rd_cmd_t           bus_rd_cmd_o,
  input  wire logic             bus_rd_gnt_i,
  output logic                  bus_wr_req_o,
  output bus_wr_cmd_t           bus_wr_cmd_o,
  input  wire logic             bus_wr_gnt_i,
  input  wire logic             bus_rd_valid_i,
  input  wire logic [BUS_W-1:0] bus_rd_data_i,
  input  wire logic             bus_rd_last_i,
  input  wire logic             bus_rd_id_i,
  input  wire logic             bus_wr_valid_i,
  output logic                  bus_wr_rdy_o
);

  icache_req_t icache_req;
  dcache_req_t dcache_req;
  tid_push_t   tid_push;
  logic icache_full, icache_empty, icache_pop;
  logic dcache_full, dcache_empty, dcache_pop;
  logic icache_rd_full, dcache_rd_full, dcache_wr_full, dcache_wr_empty;
  logic icache_rd_pop, dcache_rd_pop, dcache_wr_pop;
  logic [TID_W-1:0] icache_tid, dcache_rd_tid, dcache_wr_tid;

  assign icache_data_ack_o = icache_data_req_i & ~icache_full;
  assign dcache_data_ack_o = dcache_data_req_i & ~dcache_full;

  //////////////////////////////////////////////////
  // request queues and arbitration
  //////////////////////////////////////////////////

  sync_fifo #(.WIDTH($bits(icache_req_t)), .DEPTH(REQ_DEPTH)) u_icache_req (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .push_i(icache_data_ack_o), .data_i(icache_data_i),
    .pop_i(icache_pop), .data_o(icache_req),
    .full_o(icache_full), .empty_o(icache_empty)
  );

  sync_fifo #(.WIDTH($bits(dcache_req_t)), .DEPTH(REQ_DEPTH)) u_dcache_req (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .push_i(dcache_data_ack_o), .data_i(dcache_data_i),
    .pop_i(dcache_pop), .data_o(dcache_req),
    .full_o(dcache_full), .empty_o(dcache_empty)
  );

  req_arbiter u_arb (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .icache_req_i(icache_req), .icache_vld_i(~icache_empty),
    .dcache_req_i(dcache_req), .dcache_vld_i(~dcache_empty),
    .icache_rd_full_i(icache_rd_full), .dcache_rd_full_i(dcache_rd_full),
    .dcache_wr_full_i(dcache_wr_full),
    .bus_rd_gnt_i(bus_rd_gnt_i), .bus_wr_gnt_i(bus_wr_gnt_i),
    .icache_pop_o(icache_pop), .dcache_pop_o(dcache_pop),
    .bus_rd_req_o(bus_rd_req_o), .bus_rd_cmd_o(bus_rd_cmd_o),
    .bus_wr_req_o(bus_wr_req_o), .bus_wr_cmd_o(bus_wr_cmd_o),
    .tid_push_o(tid_push)
  );

  //////////////////////////////////////////////////
  // id tracking and return path
  //////////////////////////////////////////////////

  tid_tracker #(.META_DEPTH(META_DEPTH)) u_tid (
    .clk_i(clk_i), .rst_ni(rst_ni), .tid_push_i(tid_push),
    .icache_rd_pop_i(icache_rd_pop), .dcache_rd_pop_i(dcache_rd_pop),
    .dcache_wr_pop_i(dcache_wr_pop),
    .icache_tid_o(icache_tid), .dcache_rd_tid_o(dcache_rd_tid),
    .dcache_wr_tid_o(dcache_wr_tid),
    .icache_rd_full_o(icache_rd_full), .dcache_rd_full_o(dcache_rd_full),
    .dcache_wr_full_o(dcache_wr_full), .dcache_wr_empty_o(dcache_wr_empty)
  );

  rtrn_assembler #(.META_DEPTH(META_DEPTH)) u_rtrn (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .bus_rd_valid_i(bus_rd_valid_i), .bus_rd_data_i(bus_rd_data_i),
    .bus_rd_last_i(bus_rd_last_i), .bus_rd_id_i(bus_rd_id_i),
    .bus_wr_valid_i(bus_wr_valid_i),
    .icache_tid_i(icache_tid), .dcache_rd_tid_i(dcache_rd_tid),
    .dcache_wr_tid_i(dcache_wr_tid), .dcache_wr_empty_i(dcache_wr_empty),
    .bus_wr_rdy_o(bus_wr_rdy_o),
    .icache_rd_pop_o(icache_rd_pop), .dcache_rd_pop_o(dcache_rd_pop),
    .dcache_wr_pop_o(dcache_wr_pop),
    .icache_rtrn_vld_o(icache_rtrn_vld_o), .icache_rtrn_o(icache_rtrn_o),
    .dcache_rtrn_vld_o(dcache_rtrn_vld_o), .dcache_rtrn_o(dcache_rtrn_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_cache_bus_adapter.sv ====
/*
  Testbench for the cache bus adapter with a random bus model.
  Reads return in issue order, data word = (addr ^ A5A50000) + 4 * beat.
  Stores must be naturally aligned, as the arbiter requires.
*/
`default_nettype none

module tb_cache_bus_adapter
  import cache_bus_pkg::*;
();

  localparam int unsigned REQ_DEPTH  = 2;
  localparam int unsigned META_DEPTH = 4;
  localparam int          N_REQ      = 200;
  // about fifteen cycles per request covers line bursts and grant holds
  localparam int          CYCLE_LIMIT = N_REQ * 15;
  localparam logic [31:0] DATA_KEY   = 32'hA5A5_0000;

  typedef struct packed {
    logic [TID_W-1:0] tid;
    line_t            line;
    line_t            mask;
  } rtrn_exp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        beats;
    logic              id;
  } burst_t;

  logic clk_i, rst_ni;
  logic ic_req, ic_ack, ic_rtrn_vld, dc_req, dc_ack, dc_rtrn_vld;
  icache_req_t ic_data;
  dcache_req_t dc_data;
  icache_rtrn_t ic_rtrn;
  dcache_rtrn_t dc_rtrn;
  logic rd_req, rd_gnt, wr_req, wr_gnt, rd_valid, rd_last, rd_id, wr_valid, wr_rdy;
  logic [BUS_W-1:0] rd_data;
  bus_rd_cmd_t rd_cmd;
  bus_wr_cmd_t wr_cmd;

  int unsigned lcg_state = 54;
  int cycle, n_offered, ic_queued, dc_queued, rsp_held, hold, beat_idx;
  bit ic_acc, dc_acc, ic_pop, dc_pop, load_due;
  icache_req_t ic_sent[$];
  dcache_req_t dc_sent[$];
  rtrn_exp_t ic_exp[$], dc_rd_exp[$], dc_wr_exp[$];
  burst_t bursts[$];
  int wr_due[$];
  rtrn_exp_t exp_ic, exp_dc;
  dcache_rtrn_type_e exp_dc_type;
  bus_rd_cmd_t exp_rd_cmd;
  bus_wr_cmd_t exp_wr_cmd;

  cache_bus_adapter #(.REQ_DEPTH(REQ_DEPTH), .META_DEPTH(META_DEPTH)) dut0 (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .icache_data_req_i(ic_req), .icache_data_ack_o(ic_ack), .icache_data_i(ic_data),
    .icache_rtrn_vld_o(ic_rtrn_vld), .icache_rtrn_o(ic_rtrn),
    .dcache_data_req_i(dc_req), .dcache_data_ack_o(dc_ack), .dcache_data_i(dc_data),
    .dcache_rtrn_vld_o(dc_rtrn_vld), .dcache_rtrn_o(dc_rtrn),
    .bus_rd_req_o(rd_req), .bus_rd_cmd_o(rd_cmd), .bus_rd_gnt_i(rd_gnt),
    .bus_wr_req_o(wr_req), .bus_wr_cmd_o(wr_cmd), .bus_wr_gnt_i(wr_gnt),
    .bus_rd_valid_i(rd_valid), .bus_rd_data_i(rd_data), .bus_rd_last_i(rd_last),
    .bus_rd_id_i(rd_id), .bus_wr_valid_i(wr_valid), .bus_wr_rdy_o(wr_rdy)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run stopped at cycle %0d", cycle);
  endtask

  // swap halves so the better upper LCG bits land low
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic icache_req_t new_icache_req();
    icache_req_t r;
    r.nc    = (next_rand() % 4 == 0);
    r.paddr = next_rand() & 32'hFFFF_FFF0;
    if (r.nc) begin
      r.paddr[3:2] = 2'(next_rand());
    end
    r.tid = TID_W'(next_rand());
    return r;
  endfunction

  function automatic dcache_req_t new_dcache_req();
    dcache_req_t r;
    logic [1:0]  sz;
    r.rtype = (next_rand() % 2 == 0) ? DCACHE_STORE_REQ : DCACHE_LOAD_REQ;
    sz      = 2'(next_rand() % 3);
    r.size  = {1'b0, sz};
    r.paddr = next_rand() & ~((32'd1 << sz) - 32'd1);
    // about a third of the loads ask for a whole line
    if (r.rtype == DCACHE_LOAD_REQ && next_rand() % 3 == 0) begin
      r.size       = 3'b100;
      r.paddr[3:0] = '0;
    end
    r.data = next_rand();
    r.tid  = TID_W'(next_rand());
    return r;
  endfunction

  function automatic rtrn_exp_t expect_read(input logic [TID_W-1:0] tid,
                                            input logic [ADDR_W-1:0] addr, input bit whole);
    rtrn_exp_t e;
    e.tid  = tid;
    e.line = '0;
    e.mask = '0;
    for (int i = 0; i < LINE_BEATS; i++) begin
      if (whole || i == 0) begin
        e.line[i] = (addr ^ DATA_KEY) + 32'(4 * i);
        e.mask[i] = '1;
      end
    end
    return e;
  endfunction

  function automatic bus_rd_cmd_t read_cmd_for(input logic [ADDR_W-1:0] addr,
                                               input bit whole, input logic [2:0] size,
                                               input logic id);
    bus_rd_cmd_t c;
    c.addr = addr;
    c.size = size;
    c.blen = whole ? 2'd3 : 2'd0;
    c.id   = id;
    return c;
  endfunction

  function automatic bus_wr_cmd_t store_cmd(input dcache_req_t r);
    bus_wr_cmd_t c;
    c.addr = r.paddr;
    c.data = r.data;
    c.size = r.size;
    c.be   = BE_W'((1 << (1 << r.size[1:0])) - 1) << r.paddr[1:0];
    return c;
  endfunction

  function automatic bit drained();
    return n_offered == N_REQ && !ic_req && !dc_req && ic_sent.size() == 0 &&
           dc_sent.size() == 0 && ic_exp.size() == 0 && dc_rd_exp.size() == 0 &&
           dc_wr_exp.size() == 0 && bursts.size() == 0 && wr_due.size() == 0;
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_reset_quiet : assert property (@(posedge clk_i) !rst_ni |->
    !(ic_rtrn_vld || dc_rtrn_vld || rd_req || wr_req || ic_ack || dc_ack))
    else stop_with_error("a valid or request output was high during reset");
  a_ic_ack : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ic_ack == (ic_req && ic_queued < REQ_DEPTH))
    else stop_with_error($sformatf("Mismatch icache_data_ack_o got %h exp %h",
      $sampled(ic_ack), ic_req && ic_queued < REQ_DEPTH));
  a_dc_ack : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dc_ack == (dc_req && dc_queued < REQ_DEPTH))
    else stop_with_error($sformatf("Mismatch dcache_data_ack_o got %h exp %h",
      $sampled(dc_ack), dc_req && dc_queued < REQ_DEPTH));
  a_wr_rdy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_rdy == (rsp_held < META_DEPTH))
    else stop_with_error($sformatf("Mismatch bus_wr_rdy_o got %h exp %h",
      $sampled(wr_rdy), rsp_held < META_DEPTH));
  a_rd_cmd : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req && rd_gnt |-> rd_cmd == exp_rd_cmd)
    else stop_with_error($sformatf("Mismatch bus_rd_cmd_o got %h exp %h",
      $sampled(rd_cmd), exp_rd_cmd));
  a_wr_cmd : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_req && wr_gnt |-> wr_cmd == exp_wr_cmd)
    else stop_with_error($sformatf("Mismatch bus_wr_cmd_o got %h exp %h",
      $sampled(wr_cmd), exp_wr_cmd));
  a_rd_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req && !rd_gnt |=> rd_req && $stable(rd_cmd))
    else stop_with_error("read command changed while waiting for its grant");
  a_wr_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_req && !wr_gnt |=> wr_req && $stable(wr_cmd))
    else stop_with_error("write command changed while waiting for its grant");
  a_ic_timing : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ic_rtrn_vld == $past(rd_valid && rd_last && !rd_id))
    else stop_with_error("icache return not exactly one cycle after its last beat");
  a_dc_timing : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dc_rtrn_vld && dc_rtrn.rtype == DCACHE_LOAD_ACK) == $past(rd_valid && rd_last && rd_id))
    else stop_with_error("dcache load return not exactly one cycle after its last beat");
  a_ic_tid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ic_rtrn_vld |-> ic_rtrn.tid == exp_ic.tid)
    else stop_with_error($sformatf("Mismatch icache_rtrn_o.tid got %h exp %h",
      $sampled(ic_rtrn.tid), exp_ic.tid));
  a_ic_line : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ic_rtrn_vld |-> (ic_rtrn.line & exp_ic.mask) == exp_ic.line)
    else stop_with_error($sformatf("Mismatch icache_rtrn_o.line got %h exp %h",
      $sampled(ic_rtrn.line) & exp_ic.mask, exp_ic.line));
  a_dc_tid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dc_rtrn_vld |-> dc_rtrn.tid == exp_dc.tid && dc_rtrn.rtype == exp_dc_type)
    else stop_with_error($sformatf("Mismatch dcache_rtrn_o.rtype/tid got %h/%h exp %h/%h",
      $sampled(dc_rtrn.rtype), $sampled(dc_rtrn.tid), exp_dc_type, exp_dc.tid));
  a_dc_line : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dc_rtrn_vld |-> (dc_rtrn.line & exp_dc.mask) == exp_dc.line)
    else stop_with_error($sformatf("Mismatch dcache_rtrn_o.line got %h exp %h",
      $sampled(dc_rtrn.line) & exp_dc.mask, exp_dc.line));

  //////////////////////////////////////////////////
  // stimulus and bus model
  //////////////////////////////////////////////////

  initial begin
    rst_ni   = 1'b0;
    ic_req   = 1'b0;
    ic_data  = '0;
    dc_req   = 1'b0;
    dc_data  = '0;
    rd_gnt   = 1'b0;
    wr_gnt   = 1'b0;
    rd_valid = 1'b0;
    rd_data  = '0;
    rd_last  = 1'b0;
    rd_id    = 1'b0;
    wr_valid = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    while (!drained() && cycle < CYCLE_LIMIT) begin
      @(negedge clk_i);
      cycle++;
      // request FIFO fill after the edge that just passed
      ic_queued += int'(ic_acc) - int'(ic_pop);
      dc_queued += int'(dc_acc) - int'(dc_pop);
      // buffered write responses, one leaves per cycle without a dcache beat
      rsp_held += int'(wr_valid) - int'(rsp_held > 0 && !(rd_valid && rd_id));
      load_due = rd_valid && rd_last && rd_id;

      if (ic_rtrn_vld) begin
        if (ic_exp.size() == 0) stop_with_error("icache return without an outstanding refill");
        else exp_ic = ic_exp.pop_front();
      end
      if (dc_rtrn_vld && load_due) begin
        exp_dc_type = DCACHE_LOAD_ACK;
        if (dc_rd_exp.size() == 0) stop_with_error("dcache load return without a load");
        else exp_dc = dc_rd_exp.pop_front();
      end else if (dc_rtrn_vld) begin
        exp_dc_type = DCACHE_STORE_ACK;
        if (dc_wr_exp.size() == 0) stop_with_error("store ack without an outstanding store");
        else exp_dc = dc_wr_exp.pop_front();
      end

      // occasional grant holds long enough to fill the request FIFOs
      if (hold > 0) hold--;
      else if (next_rand() % 64 == 0) hold = 8 + int'(next_rand() % 8);
      rd_gnt = (hold == 0) && (next_rand() % 2 == 0);
      wr_gnt = (hold == 0) && (next_rand() % 2 == 0);

      rd_valid = 1'b0;
      rd_last  = 1'b0;
      if (bursts.size() != 0 && next_rand() % 4 != 0) begin
        rd_valid = 1'b1;
        rd_id    = bursts[0].id;
        rd_data  = (bursts[0].addr ^ DATA_KEY) + 32'(4 * beat_idx);
        rd_last  = (beat_idx == int'(bursts[0].beats) - 1);
        beat_idx = rd_last ? 0 : beat_idx + 1;
        if (rd_last) void'(bursts.pop_front());
      end
      wr_valid = 1'b0;
      if (wr_due.size() != 0 && wr_due[0] <= cycle && wr_rdy) begin
        wr_valid = 1'b1;
        void'(wr_due.pop_front());
      end

      if (ic_acc) ic_req = 1'b0;
      if (dc_acc) dc_req = 1'b0;
      if (!ic_req && n_offered < N_REQ && next_rand() % 2 == 0) begin
        ic_data = new_icache_req();
        ic_req  = 1'b1;
        n_offered++;
      end
      if (!dc_req && n_offered < N_REQ && next_rand() % 2 == 0) begin
        dc_data = new_dcache_req();
        dc_req  = 1'b1;
        n_offered++;
      end

      // outputs have settled, note what the coming edge accepts
      #1;
      ic_pop = 1'b0;
      dc_pop = 1'b0;
      if (rd_req && rd_gnt && rd_cmd.id) begin
        if (dc_sent.size() == 0 || dc_sent[0].rtype == DCACHE_STORE_REQ) begin
          stop_with_error("dcache read command without a queued load");
        end else begin
          exp_rd_cmd = read_cmd_for(dc_sent[0].paddr, dc_sent[0].size[2],
                                    dc_sent[0].size[2] ? 3'd2 : dc_sent[0].size, 1'b1);
          dc_rd_exp.push_back(expect_read(dc_sent[0].tid, dc_sent[0].paddr,
                                          dc_sent[0].size[2]));
          void'(dc_sent.pop_front());
          dc_pop = 1'b1;
        end
      end else if (rd_req && rd_gnt) begin
        if (ic_sent.size() == 0) begin
          stop_with_error("icache read command without a queued refill");
        end else begin
          exp_rd_cmd = read_cmd_for(ic_sent[0].paddr, !ic_sent[0].nc, 3'd2, 1'b0);
          ic_exp.push_back(expect_read(ic_sent[0].tid, ic_sent[0].paddr, !ic_sent[0].nc));
          void'(ic_sent.pop_front());
          ic_pop = 1'b1;
        end
      end
      if (rd_req && rd_gnt) begin
        bursts.push_back(burst_t'{rd_cmd.addr, 3'(rd_cmd.blen) + 3'd1, rd_cmd.id});
      end
      if (wr_req && wr_gnt) begin
        if (dc_sent.size() == 0 || dc_sent[0].rtype != DCACHE_STORE_REQ) begin
          stop_with_error("write command without a queued store");
        end else begin
          exp_wr_cmd = store_cmd(dc_sent[0]);
          dc_wr_exp.push_back(rtrn_exp_t'{dc_sent[0].tid, '0, '0});
          wr_due.push_back(cycle + 1 + int'(next_rand() % 3));
          void'(dc_sent.pop_front());
          dc_pop = 1'b1;
        end
      end
      ic_acc = ic_req && ic_ack;
      dc_acc = dc_req && dc_ack;
      if (ic_acc) ic_sent.push_back(ic_data);
      if (dc_acc) dc_sent.push_back(dc_data);
    end

    if (drained()) begin
      repeat (2) @(posedge clk_i);
      $display("Test OK");
      $finish;
    end else begin
      $display("Timeout after %0d cycles with requests still outstanding", cycle);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/cache_bus_pkg.sv
src/sync_fifo.sv
src/req_arbiter.sv
src/tid_tracker.sv
src/rtrn_assembler.sv
src/cache_bus_adapter.sv
verif/tb_cache_bus_adapter.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the adapter and its testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f filelist.f --top-module tb_cache_bus_adapter
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_cache_bus_adapter 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
